// ==== tb/aes_input_trace.txt ====
# M <command word> <expected decrypt> <expected key size>
# B <word 0> <word 1> <word 2> <word 3> <expected last> <expected index>, all in hex
M 00000000 0 0
B 01000000 01000001 01000002 01000003 0 00
B 01010000 01010001 01010002 01010003 0 01
B 01020000 01020001 01020002 01020003 1 02
M 00000003 1 1
B 02000000 02000001 02000002 02000003 0 00
B 02010000 02010001 02010002 02010003 0 01
B 02020000 02020001 02020002 02020003 0 02
B 02030000 02030001 02030002 02030003 1 03
M 00000004 0 2
B 03000000 03000001 03000002 03000003 0 00
B 03010000 03010001 03010002 03010003 1 01
M a5a5a5a7 1 3
B deadbeef 0badf00d 12345678 9abcdef0 0 00
B 04010000 04010001 04010002 04010003 0 01
B 04020000 04020001 04020002 04020003 0 02
B 04030000 04030001 04030002 04030003 0 03
B 04040000 04040001 04040002 04040003 1 04
M 00000010 0 0
B 05000000 05000001 05000002 05000003 1 00
M fffffffd 1 2
B 06000000 06000001 06000002 06000003 0 00
B 06010000 06010001 06010002 06010003 1 01

// ==== aes_input.f ====
source/aes_pkg.sv
source/aes_entry_if.sv
source/aes_word_assembler.sv
source/aes_entry_fifo.sv
source/aes_cmd_dispatcher.sv
source/aes_input_top.sv
tb/aes_input_properties.sv
tb/aes_input_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module aes_input_tb \
	-f aes_input.f -o aes_input_sim > build.log 2>&1 \
	&& ./obj_dir/aes_input_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb/aes_input_tb.sv ====
// Trace-driven testbench for the AES input front end with back-pressure and scoreboard
`timescale 1ns/1ps
`default_nettype none

module aes_input_tb;

	localparam string TRACE_PATH = "tb/aes_input_trace.txt";
	// Output stall window, counted in cycles after reset
	localparam int STALL_START = 10;
	localparam int STALL_LEN = 80;
	localparam int MIN_BUSY_RUN = 10;

	typedef struct packed {
		logic tlast;
		aes_pkg::word_t data;
	} bus_word_t;

	typedef struct packed {
		aes_pkg::block_t blk;
		logic decrypt;
		aes_pkg::key_size_t key_size;
		aes_pkg::blk_index_t index;
		logic last;
	} exp_block_t;

	logic clk;
	logic reset;
	logic bus_wren;
	logic bus_tlast;
	aes_pkg::word_t bus_data;
	logic bus_busy;
	logic out_valid;
	logic out_ready;
	aes_pkg::block_t out_block;
	logic out_decrypt;
	aes_pkg::key_size_t out_key_size;
	aes_pkg::blk_index_t out_index;
	logic out_last;

	bus_word_t words_q[$];
	exp_block_t exp_q[$];
	int n_blocks;
	int checked;
	int mismatch_count;
	int other_count;
	int cyc;
	int busy_run;
	int max_busy_run;
	logic running;
	logic loaded;

	aes_input_top #(
		.FIFO_DEPTH (4)
	) u_dut (
		.clk          (clk),
		.reset        (reset),
		.bus_wren     (bus_wren),
		.bus_tlast    (bus_tlast),
		.bus_data     (bus_data),
		.bus_busy     (bus_busy),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_block    (out_block),
		.out_decrypt  (out_decrypt),
		.out_key_size (out_key_size),
		.out_index    (out_index),
		.out_last     (out_last)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Builds the bus word list and the expected block list from the trace
	task automatic load_trace();
		int fd;
		int code;
		logic [8*8-1:0] tag;
		logic [8*200-1:0] rest;
		aes_pkg::word_t cmd, w0, w1, w2, w3;
		logic dec, lst, cur_dec;
		aes_pkg::key_size_t key, cur_key;
		aes_pkg::blk_index_t idx;
		cur_dec = 1'b0;
		cur_key = '0;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			other_count++;
			$display("Cannot open the trace file %s", TRACE_PATH);
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tag);
				if (code == 1) begin
					if (tag == "#") begin
						code = $fgets(rest, fd);
					end else if (tag == "M") begin
						code = $fscanf(fd, "%h %h %h", cmd, dec, key);
						cur_dec = dec;
						cur_key = key;
						words_q.push_back({1'b0, cmd});
					end else if (tag == "B") begin
						code = $fscanf(fd, "%h %h %h %h %h %h", w0, w1, w2, w3, lst, idx);
						words_q.push_back({1'b0, w0});
						words_q.push_back({1'b0, w1});
						words_q.push_back({1'b0, w2});
						// tlast rides on the fourth word only
						words_q.push_back({lst, w3});
						exp_q.push_back('{blk: {w3, w2, w1, w0}, decrypt: cur_dec,
							key_size: cur_key, index: idx, last: lst});
					end else begin
						other_count++;
						$display("Unknown line tag in the trace file");
					end
				end
			end
			$fclose(fd);
		end
		n_blocks = exp_q.size();
	endtask

	// Holds one word on the bus until a cycle with bus_busy low takes it
	task automatic send_word(input aes_pkg::word_t data, input logic tlast);
		logic taken;
		taken = 1'b0;
		bus_wren = 1'b1;
		bus_data = data;
		bus_tlast = tlast;
		while (!taken) begin
			// bus_busy is stable between edges
			taken = !bus_busy;
			@(negedge clk);
		end
		bus_wren = 1'b0;
	endtask

	// Output side, new ready value first, then the transfer it allows
	always @(negedge clk) begin
		exp_block_t e;
		if (running) begin
			cyc++;
			if (cyc >= STALL_START && cyc < STALL_START + STALL_LEN) begin
				out_ready = 1'b0;
				busy_run = bus_busy ? busy_run + 1 : 0;
				if (busy_run > max_busy_run) begin
					max_busy_run = busy_run;
				end
			end else begin
				// About one cycle in four stalled
				out_ready = ($urandom % 4) != 0;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					other_count++;
					$display("Output block %0d arrived with no block left to expect", checked);
				end else begin
					e = exp_q.pop_front();
					if (out_block !== e.blk) begin
						mismatch_count++;
						$display("MISMATCH block %0d out_block expected %h actual %h",
							checked, e.blk, out_block);
					end
					if (out_decrypt !== e.decrypt) begin
						mismatch_count++;
						$display("MISMATCH block %0d out_decrypt expected %h actual %h",
							checked, e.decrypt, out_decrypt);
					end
					if (out_key_size !== e.key_size) begin
						mismatch_count++;
						$display("MISMATCH block %0d out_key_size expected %h actual %h",
							checked, e.key_size, out_key_size);
					end
					if (out_index !== e.index) begin
						mismatch_count++;
						$display("MISMATCH block %0d out_index expected %h actual %h",
							checked, e.index, out_index);
					end
					if (out_last !== e.last) begin
						mismatch_count++;
						$display("MISMATCH block %0d out_last expected %h actual %h",
							checked, e.last, out_last);
					end
				end
				checked++;
			end
		end
	end

	initial begin
		int gap;
		void'($urandom(9));
		reset = 1'b1;
		bus_wren = 1'b0;
		bus_tlast = 1'b0;
		bus_data = '0;
		out_ready = 1'b0;
		running = 1'b0;
		loaded = 1'b0;
		load_trace();
		loaded = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		if (out_valid !== 1'b0 || bus_busy !== 1'b0) begin
			other_count++;
			$display("out_valid or bus_busy not low after reset");
		end
		running = 1'b1;
		foreach (words_q[i]) begin
			gap = $urandom % 4;
			repeat (gap) @(negedge clk);
			send_word(words_q[i].data, words_q[i].tlast);
		end
		while (exp_q.size() != 0) @(negedge clk);
		// Any extra block shows up here as an unexpected transfer
		repeat (20) @(negedge clk);
		if (n_blocks == 0) begin
			other_count++;
			$display("The trace holds no blocks");
		end
		if (max_busy_run < MIN_BUSY_RUN) begin
			other_count++;
			$display("bus_busy did not stay high during the output stall, longest run %0d",
				max_busy_run);
		end
		$display("Checked %0d blocks: %0d mismatches, %0d other errors",
			checked, mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog sized from the trace length plus the stall
	initial begin
		int limit;
		wait (loaded);
		limit = (words_q.size() + n_blocks) * 40 + STALL_LEN + 20;
		repeat (limit) @(posedge clk);
		other_count++;
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Checked %0d blocks: %0d mismatches, %0d other errors",
			checked, mismatch_count, other_count);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/aes_input_properties.sv ====
// Concurrent assertions on the bus and output handshakes, bound to the front end top
`timescale 1ns/1ps
`default_nettype none

module aes_input_properties (
	input logic                clk,
	input logic                reset,
	input logic                bus_busy,
	input logic                asm_valid,
	input logic                asm_ready,
	input logic                out_valid,
	input logic                out_ready,
	input aes_pkg::block_t     out_block,
	input logic                out_decrypt,
	input aes_pkg::key_size_t  out_key_size,
	input aes_pkg::blk_index_t out_index,
	input logic                out_last
);

	// Stalled output keeps its block and tags
	hold_output: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_block) && $stable(out_decrypt)
			&& $stable(out_key_size) && $stable(out_index) && $stable(out_last))
	else $error("Output changed while out_ready was low");

	// Busy clears only once the FIFO took the pending entry
	busy_release: assert property (@(posedge clk) disable iff (reset)
		$fell(bus_busy) |-> $past(asm_valid && asm_ready))
	else $error("bus_busy fell without an entry transfer into the FIFO");

	reset_quiet: assert property (@(posedge clk) $past(reset) |-> !out_valid)
	else $error("out_valid high during reset");

endmodule

bind aes_input_top aes_input_properties u_props (
	.clk          (clk),
	.reset        (reset),
	.bus_busy     (bus_busy),
	.asm_valid    (asm_to_fifo.valid),
	.asm_ready    (asm_to_fifo.ready),
	.out_valid    (out_valid),
	.out_ready    (out_ready),
	.out_block    (out_block),
	.out_decrypt  (out_decrypt),
	.out_key_size (out_key_size),
	.out_index    (out_index),
	.out_last     (out_last)
);

`default_nettype wire

// ==== source/aes_input_top.sv ====
// Top level of the AES input front end: assembler, entry FIFO and dispatcher
`timescale 1ns/1ps
`default_nettype none

module aes_input_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                clk,
	input  logic                reset,

	// Write bus side
	input  logic                bus_wren,
	input  logic                bus_tlast,
	input  aes_pkg::word_t      bus_data,
	output logic                bus_busy,

	// Block output side
	output logic                out_valid,
	input  logic                out_ready,
	output aes_pkg::block_t     out_block,
	output logic                out_decrypt,
	output aes_pkg::key_size_t  out_key_size,
	output aes_pkg::blk_index_t out_index,
	output logic                out_last
);

	aes_entry_if asm_to_fifo ();
	aes_entry_if fifo_to_disp ();

	aes_word_assembler u_asm (
		.clk       (clk),
		.reset     (reset),
		.bus_wren  (bus_wren),
		.bus_tlast (bus_tlast),
		.bus_data  (bus_data),
		.bus_busy  (bus_busy),
		.ent       (asm_to_fifo.source)
	);

	// Commands and blocks share one queue
	aes_entry_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk   (clk),
		.reset (reset),
		.wr    (asm_to_fifo.sink),
		.rd    (fifo_to_disp.source)
	);

	aes_cmd_dispatcher u_disp (
		.clk          (clk),
		.reset        (reset),
		.ent          (fifo_to_disp.sink),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_block    (out_block),
		.out_decrypt  (out_decrypt),
		.out_key_size (out_key_size),
		.out_index    (out_index),
		.out_last     (out_last)
	);

endmodule

`default_nettype wire

// ==== source/aes_cmd_dispatcher.sv ====
// Command decoder and block dispatcher with a one-deep tagged output register
`timescale 1ns/1ps
`default_nettype none

module aes_cmd_dispatcher (
	input  logic                clk,
	input  logic                reset,
	aes_entry_if.sink           ent,
	output logic                out_valid,
	input  logic                out_ready,
	output aes_pkg::block_t     out_block,
	output logic                out_decrypt,
	output aes_pkg::key_size_t  out_key_size,
	output aes_pkg::blk_index_t out_index,
	output logic                out_last
);

	typedef enum logic {
		expect_cmd,
		expect_block
	} disp_state_t;

	disp_state_t state;

	// Fields of the current message
	logic cmd_decrypt;
	aes_pkg::key_size_t cmd_key_size;
	aes_pkg::blk_index_t blk_index;

	logic out_free;
	logic pop;
	logic pop_cmd;
	logic pop_blk;

	// Output register empty or being emptied this cycle
	assign out_free = !out_valid || out_ready;

	// Commands never wait for the output side
	assign ent.ready = (state == expect_cmd) || out_free;

	assign pop = ent.valid && ent.ready;
	assign pop_cmd = pop && (state == expect_cmd);
	assign pop_blk = pop && (state == expect_block);

	// Command decode
	always_ff @(posedge clk) begin
		if (pop_cmd) begin
			cmd_decrypt <= ent.entry[aes_pkg::CMD_DECRYPT_BIT];
			// Reserved code 3 is passed on as is
			cmd_key_size <= ent.entry[aes_pkg::CMD_KEY_LSB +: aes_pkg::KEY_SIZE_W];
		end
	end

	// Tagged output payload
	always_ff @(posedge clk) begin
		if (pop_blk) begin
			out_block <= ent.entry[aes_pkg::BLOCK_W-1:0];
			out_decrypt <= cmd_decrypt;
			out_key_size <= cmd_key_size;
			out_index <= blk_index;
			out_last <= ent.last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (pop_blk) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Message state and block numbering
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= expect_cmd;
			blk_index <= '0;
		end else begin
			case (state)
				expect_cmd: begin
					if (pop_cmd) begin
						state <= expect_block;
						blk_index <= '0;
					end
				end
				expect_block: begin
					if (pop_blk) begin
						blk_index <= blk_index + 1'b1;
						// Final block closes the message
						if (ent.last) begin
							state <= expect_cmd;
						end
					end
				end
				default: begin
					state <= expect_cmd;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/aes_entry_fifo.sv ====
// Synchronous circular FIFO of 129-bit entries with full and empty tracking
`timescale 1ns/1ps
`default_nettype none

module aes_entry_fifo #(
	// Must be a power of two, at least 2
	parameter int FIFO_DEPTH = 16
) (
	input  logic        clk,
	input  logic        reset,
	aes_entry_if.sink   wr,
	aes_entry_if.source rd
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);

	// Extra top bit tells a full ring from an empty one
	typedef logic [ADDR_W:0] ptr_t;

	aes_pkg::entry_t mem [FIFO_DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;

	logic full;
	logic empty;
	logic do_write;
	logic do_read;
	aes_pkg::entry_t head;

	assign empty = (wr_ptr == rd_ptr);
	// Same slot but one lap apart
	assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	assign do_write = wr.valid && !full;
	assign do_read = rd.ready && !empty;

	assign wr.ready = !full;

	// Head entry is shown as soon as it is written
	assign head = mem[rd_ptr[ADDR_W-1:0]];
	assign rd.valid = !empty;
	assign rd.entry = head;
	assign rd.last = head[aes_pkg::ENTRY_LAST_BIT];

	// Storage
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr[ADDR_W-1:0]] <= {wr.last, wr.entry[aes_pkg::BLOCK_W-1:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (do_write) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (do_read) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/aes_word_assembler.sv ====
// Bus word assembler that captures commands and packs payload words into block entries
`timescale 1ns/1ps
`default_nettype none

module aes_word_assembler (
	input  logic           clk,
	input  logic           reset,
	input  logic           bus_wren,
	input  logic           bus_tlast,
	input  aes_pkg::word_t bus_data,
	output logic           bus_busy,
	aes_entry_if.source    ent
);

	typedef enum logic {
		get_cmd,
		get_payload
	} asm_state_t;

	asm_state_t state;

	// Position of the next payload word within its block
	logic [1:0] word_cnt;

	// Entry waiting for the FIFO
	logic entry_valid;
	aes_pkg::entry_t entry_q;

	logic bus_accept;
	logic cmd_done;
	logic blk_done;
	aes_pkg::block_t blk_next;

	// Any pending entry stalls the bus
	assign bus_busy = entry_valid;
	assign bus_accept = bus_wren && !entry_valid;

	assign cmd_done = bus_accept && (state == get_cmd);
	assign blk_done = bus_accept && (state == get_payload) &&
		(word_cnt == 2'(aes_pkg::WORDS_PER_BLOCK - 1));

	// New word enters at the top, so the first word of a group
	// ends up in bits 31..0 after four shifts
	assign blk_next = {bus_data, entry_q[aes_pkg::BLOCK_W-1:aes_pkg::WORD_W]};

	assign ent.valid = entry_valid;
	assign ent.entry = entry_q;
	assign ent.last = entry_q[aes_pkg::ENTRY_LAST_BIT];

	// Entry payload, shifted word by word
	always_ff @(posedge clk) begin
		if (cmd_done) begin
			// Command goes out zero-extended, last flag clear
			entry_q <= aes_pkg::entry_t'(bus_data);
		end else if (bus_accept) begin
			entry_q <= {bus_tlast, blk_next};
		end
	end

	// Entry handshake towards the FIFO
	always_ff @(posedge clk) begin
		if (reset) begin
			entry_valid <= 1'b0;
		end else if (cmd_done || blk_done) begin
			entry_valid <= 1'b1;
		end else if (ent.ready) begin
			entry_valid <= 1'b0;
		end
	end

	// Message framing
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= get_cmd;
			word_cnt <= '0;
		end else begin
			case (state)
				get_cmd: begin
					if (cmd_done) begin
						state <= get_payload;
						word_cnt <= '0;
					end
				end
				get_payload: begin
					if (bus_accept) begin
						// Wraps to zero after the fourth word
						word_cnt <= word_cnt + 2'd1;
						if (bus_tlast) begin
							state <= get_cmd;
						end
					end
				end
				default: begin
					state <= get_cmd;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/aes_entry_if.sv ====
// Valid/ready interface carrying one FIFO entry, with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface aes_entry_if;
	logic valid;
	logic ready;
	aes_pkg::entry_t entry;
	// Copy of the entry's top bit, kept separate for readability
	logic last;

	// Transfer on a clock edge with valid and ready both high
	modport source (
		output valid,
		output entry,
		output last,
		input  ready
	);

	modport sink (
		input  valid,
		input  entry,
		input  last,
		output ready
	);
endinterface

`default_nettype wire

// ==== source/aes_pkg.sv ====
// Shared word, block and entry types, command field positions and block geometry
`default_nettype none

package aes_pkg;

	// Bus word and AES block geometry
	localparam int WORD_W = 32;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int BLOCK_W = WORD_W * WORDS_PER_BLOCK;

	// The FIFO entry holds the last flag just above the 128-bit payload
	localparam int ENTRY_LAST_BIT = BLOCK_W;
	localparam int ENTRY_W = BLOCK_W + 1;

	// Decoded command field widths
	localparam int KEY_SIZE_W = 2;
	localparam int BLK_INDEX_W = 8;

	// Command word bit positions
	// Bit 0 set means decrypt
	localparam int CMD_DECRYPT_BIT = 0;
	// Key size code sits in bits 2..1
	localparam int CMD_KEY_LSB = 1;

	// One bus word
	typedef logic [WORD_W-1:0] word_t;

	// One AES block, first bus word in the low bits
	typedef logic [BLOCK_W-1:0] block_t;

	// FIFO entry, last flag on top of a block or a zero-extended command
	typedef logic [ENTRY_W-1:0] entry_t;

	// 0 for 128-bit, 1 for 192-bit, 2 for 256-bit keys; 3 reserved
	typedef logic [KEY_SIZE_W-1:0] key_size_t;

	// Block number within a message, wraps at 256
	typedef logic [BLK_INDEX_W-1:0] blk_index_t;

endpackage

`default_nettype wire
